//--- source/rs_pkg.sv
package rs_pkg;

    localparam int rs_entries = 16;
    localparam int rs_index_width = 4;

    localparam int data_width = 32;
    localparam int pc_width = 32;
    localparam int tag_width = 8;
    localparam int aluop_width = 4;

    // result sources, lower index wins on a tie
    localparam int num_sources = 4;
    localparam int src_alu = 0;
    localparam int src_mul = 1;
    localparam int src_div = 2;
    localparam int src_mem = 3;

    // one-hot of the lowest set bit, zero when empty
    function automatic logic [rs_entries-1:0] lowest_one(
        input logic [rs_entries-1:0] vec
    );
        return vec & (~vec + 1'b1);
    endfunction

    // returns {ready, data} after looking at the result buses
    function automatic logic [data_width:0] resolve_operand(
        input logic [tag_width-1:0] tag,
        input logic ready,
        input logic [data_width-1:0] data,
        input logic [num_sources-1:0] src_valid,
        input logic [num_sources-1:0][tag_width-1:0] src_tag,
        input logic [num_sources-1:0][data_width-1:0] src_data
    );
        logic [data_width:0] result;
        result = {ready, data};
        if (!ready) begin
            // walk down so the lowest matching source is applied last
            for (int s = num_sources - 1; s >= 0; s--) begin
                if (src_valid[s] && src_tag[s] == tag) begin
                    result = {1'b1, src_data[s]};
                end
            end
        end
        return result;
    endfunction

endpackage

//--- source/rs_interfaces.sv
interface wakeup_if import rs_pkg::*; ();

    logic [num_sources-1:0] valid;
    logic [num_sources-1:0][tag_width-1:0] tag;
    logic [num_sources-1:0][data_width-1:0] data;

    modport source (
        output valid,
        output tag,
        output data
    );

    modport sink (
        input valid,
        input tag,
        input data
    );

endinterface

interface dispatch_if import rs_pkg::*; ();

    logic [pc_width-1:0] pc;
    logic [tag_width-1:0] rd;
    logic [aluop_width-1:0] aluop;
    logic [tag_width-1:0] tag1;
    logic [tag_width-1:0] tag2;
    logic [data_width-1:0] data1;
    logic [data_width-1:0] data2;
    logic ready1;
    logic ready2;

    modport source (
        output pc, rd, aluop,
        output tag1, tag2,
        output data1, data2,
        output ready1, ready2
    );

    modport sink (
        input pc, rd, aluop,
        input tag1, tag2,
        input data1, data2,
        input ready1, ready2
    );

endinterface

interface entry_read_if import rs_pkg::*; ();

    logic [rs_entries-1:0][pc_width-1:0] pc;
    logic [rs_entries-1:0][tag_width-1:0] rd;
    logic [rs_entries-1:0][aluop_width-1:0] aluop;
    logic [rs_entries-1:0][data_width-1:0] data1;
    logic [rs_entries-1:0][data_width-1:0] data2;

    modport source (output pc, rd, aluop, data1, data2);
    modport sink (input pc, rd, aluop, data1, data2);

endinterface

//--- source/rs_operand_forward.sv
module rs_operand_forward import rs_pkg::*; (
    input logic [pc_width-1:0] dispatch_pc,
    input logic [tag_width-1:0] dispatch_rd,
    input logic [aluop_width-1:0] dispatch_aluop,
    input logic [tag_width-1:0] dispatch_tag1,
    input logic [tag_width-1:0] dispatch_tag2,
    input logic [data_width-1:0] dispatch_data1,
    input logic [data_width-1:0] dispatch_data2,
    input logic dispatch_ready1,
    input logic dispatch_ready2,

    input logic alu_valid,
    input logic [tag_width-1:0] alu_tag,
    input logic [data_width-1:0] alu_data,
    input logic mul_valid,
    input logic [tag_width-1:0] mul_tag,
    input logic [data_width-1:0] mul_data,
    input logic div_valid,
    input logic [tag_width-1:0] div_tag,
    input logic [data_width-1:0] div_data,
    input logic mem_read,
    input logic [tag_width-1:0] mem_tag,
    input logic [data_width-1:0] mem_data,

    wakeup_if.source wakeup,
    dispatch_if.source dispatch
);

    logic [num_sources-1:0] src_valid;
    logic [num_sources-1:0][tag_width-1:0] src_tag;
    logic [num_sources-1:0][data_width-1:0] src_data;

    always_comb begin
        src_valid[src_alu] = alu_valid;
        src_tag[src_alu] = alu_tag;
        src_data[src_alu] = alu_data;

        src_valid[src_mul] = mul_valid;
        src_tag[src_mul] = mul_tag;
        src_data[src_mul] = mul_data;

        src_valid[src_div] = div_valid;
        src_tag[src_div] = div_tag;
        src_data[src_div] = div_data;

        src_valid[src_mem] = mem_read; // load data only on a read
        src_tag[src_mem] = mem_tag;
        src_data[src_mem] = mem_data;
    end

    assign wakeup.valid = src_valid;
    assign wakeup.tag = src_tag;
    assign wakeup.data = src_data;

    assign dispatch.pc = dispatch_pc;
    assign dispatch.rd = dispatch_rd;
    assign dispatch.aluop = dispatch_aluop;
    assign dispatch.tag1 = dispatch_tag1;
    assign dispatch.tag2 = dispatch_tag2;

    // each operand checked against the buses on its own
    assign {dispatch.ready1, dispatch.data1} = resolve_operand(
        dispatch_tag1, dispatch_ready1, dispatch_data1, src_valid, src_tag, src_data
    );

    assign {dispatch.ready2, dispatch.data2} = resolve_operand(
        dispatch_tag2, dispatch_ready2, dispatch_data2, src_valid, src_tag, src_data
    );

endmodule

//--- source/rs_entry_array.sv
module rs_entry_array import rs_pkg::*; (
    input logic clk,
    input logic reset,
    input logic [rs_entries-1:0] alloc_onehot,
    wakeup_if.sink wakeup,
    dispatch_if.sink dispatch,
    output logic [rs_entries-1:0] operands_ready,
    entry_read_if.source entries
);

    logic [rs_entries-1:0][pc_width-1:0] pc_q;
    logic [rs_entries-1:0][tag_width-1:0] rd_q;
    logic [rs_entries-1:0][aluop_width-1:0] aluop_q;
    logic [rs_entries-1:0][tag_width-1:0] tag1_q;
    logic [rs_entries-1:0][tag_width-1:0] tag2_q;
    logic [rs_entries-1:0][data_width-1:0] data1_q;
    logic [rs_entries-1:0][data_width-1:0] data2_q;
    logic [rs_entries-1:0] ready1_q;
    logic [rs_entries-1:0] ready2_q;

    logic [rs_entries-1:0][data_width-1:0] data1_next;
    logic [rs_entries-1:0][data_width-1:0] data2_next;
    logic [rs_entries-1:0] ready1_next;
    logic [rs_entries-1:0] ready2_next;

    // wakeup first, a new dispatch overrides the slot
    always_comb begin
        for (int i = 0; i < rs_entries; i++) begin
            {ready1_next[i], data1_next[i]} = resolve_operand(
                tag1_q[i], ready1_q[i], data1_q[i], wakeup.valid, wakeup.tag, wakeup.data
            );
            {ready2_next[i], data2_next[i]} = resolve_operand(
                tag2_q[i], ready2_q[i], data2_q[i], wakeup.valid, wakeup.tag, wakeup.data
            );
            if (alloc_onehot[i]) begin
                ready1_next[i] = dispatch.ready1;
                data1_next[i] = dispatch.data1;
                ready2_next[i] = dispatch.ready2;
                data2_next[i] = dispatch.data2;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ready1_q <= '0;
            ready2_q <= '0;
        end else begin
            ready1_q <= ready1_next;
            ready2_q <= ready2_next;
        end
    end

    always_ff @(posedge clk) begin
        data1_q <= data1_next;
        data2_q <= data2_next;
        for (int i = 0; i < rs_entries; i++) begin
            if (alloc_onehot[i]) begin
                pc_q[i] <= dispatch.pc;
                rd_q[i] <= dispatch.rd;
                aluop_q[i] <= dispatch.aluop;
                tag1_q[i] <= dispatch.tag1;
                tag2_q[i] <= dispatch.tag2;
            end
        end
    end

    // free slots may look ready, control masks with busy
    assign operands_ready = ready1_q & ready2_q;

    assign entries.pc = pc_q;
    assign entries.rd = rd_q;
    assign entries.aluop = aluop_q;
    assign entries.data1 = data1_q;
    assign entries.data2 = data2_q;

endmodule

//--- source/rs_control.sv
module rs_control import rs_pkg::*; (
    input logic clk,
    input logic reset,
    input logic dispatch_valid,
    input logic [rs_entries-1:0] operands_ready,
    output logic [rs_entries-1:0] alloc_onehot,
    output logic [rs_entries-1:0] grant_onehot,
    output logic full
);

    logic [rs_entries-1:0] busy_q;
    logic [rs_entries-1:0] free_slots;
    logic [rs_entries-1:0] issuable;

    assign free_slots = ~busy_q;
    assign issuable = busy_q & operands_ready;

    assign full = &busy_q;

    // dispatch while full is dropped
    assign alloc_onehot = (dispatch_valid && !full) ? lowest_one(free_slots) : '0;

    // lowest slot goes first
    assign grant_onehot = lowest_one(issuable);

    // alloc only hits free slots and grant only busy ones
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy_q <= '0;
        end else begin
            busy_q <= (busy_q & ~grant_onehot) | alloc_onehot;
        end
    end

endmodule

//--- source/rs_issue_register.sv
module rs_issue_register import rs_pkg::*; (
    input logic clk,
    input logic reset,
    input logic [rs_entries-1:0] grant_onehot,
    entry_read_if.sink entries,
    output logic issue_valid,
    output logic [pc_width-1:0] issue_pc,
    output logic [tag_width-1:0] issue_rd,
    output logic [aluop_width-1:0] issue_aluop,
    output logic [data_width-1:0] issue_operand1,
    output logic [data_width-1:0] issue_operand2
);

    logic [rs_index_width-1:0] grant_index;

    // grant is one-hot, so at most one hit
    always_comb begin
        grant_index = '0;
        for (int i = 0; i < rs_entries; i++) begin
            if (grant_onehot[i]) begin
                grant_index = rs_index_width'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= |grant_onehot;
        end
    end

    always_ff @(posedge clk) begin
        issue_pc <= entries.pc[grant_index];
        issue_rd <= entries.rd[grant_index];
        issue_aluop <= entries.aluop[grant_index];
        issue_operand1 <= entries.data1[grant_index];
        issue_operand2 <= entries.data2[grant_index];
    end

endmodule

//--- source/div_reservation_station.sv
module div_reservation_station import rs_pkg::*; (
    input logic clk,
    input logic reset,

    input logic dispatch_valid,
    input logic [pc_width-1:0] dispatch_pc,
    input logic [tag_width-1:0] dispatch_rd,
    input logic [aluop_width-1:0] dispatch_aluop,
    input logic [tag_width-1:0] dispatch_tag1,
    input logic [tag_width-1:0] dispatch_tag2,
    input logic [data_width-1:0] dispatch_data1,
    input logic [data_width-1:0] dispatch_data2,
    input logic dispatch_ready1,
    input logic dispatch_ready2,

    input logic alu_valid,
    input logic [tag_width-1:0] alu_tag,
    input logic [data_width-1:0] alu_data,
    input logic mul_valid,
    input logic [tag_width-1:0] mul_tag,
    input logic [data_width-1:0] mul_data,
    input logic div_valid,
    input logic [tag_width-1:0] div_tag,
    input logic [data_width-1:0] div_data,
    input logic mem_read,
    input logic [tag_width-1:0] mem_tag,
    input logic [data_width-1:0] mem_data,

    output logic full,
    output logic issue_valid,
    output logic [pc_width-1:0] issue_pc,
    output logic [tag_width-1:0] issue_rd,
    output logic [aluop_width-1:0] issue_aluop,
    output logic [data_width-1:0] issue_operand1,
    output logic [data_width-1:0] issue_operand2
);

    logic [rs_entries-1:0] alloc_onehot;
    logic [rs_entries-1:0] operands_ready;
    logic [rs_entries-1:0] grant_onehot;

    wakeup_if wakeup_bus ();
    dispatch_if dispatch_bus ();
    entry_read_if entry_bus ();

    rs_operand_forward i_rs_operand_forward (
        .dispatch_pc(dispatch_pc),
        .dispatch_rd(dispatch_rd),
        .dispatch_aluop(dispatch_aluop),
        .dispatch_tag1(dispatch_tag1),
        .dispatch_tag2(dispatch_tag2),
        .dispatch_data1(dispatch_data1),
        .dispatch_data2(dispatch_data2),
        .dispatch_ready1(dispatch_ready1),
        .dispatch_ready2(dispatch_ready2),
        .alu_valid(alu_valid),
        .alu_tag(alu_tag),
        .alu_data(alu_data),
        .mul_valid(mul_valid),
        .mul_tag(mul_tag),
        .mul_data(mul_data),
        .div_valid(div_valid),
        .div_tag(div_tag),
        .div_data(div_data),
        .mem_read(mem_read),
        .mem_tag(mem_tag),
        .mem_data(mem_data),
        .wakeup(wakeup_bus.source),
        .dispatch(dispatch_bus.source)
    );

    rs_entry_array i_rs_entry_array (
        .clk(clk),
        .reset(reset),
        .alloc_onehot(alloc_onehot),
        .wakeup(wakeup_bus.sink),
        .dispatch(dispatch_bus.sink),
        .operands_ready(operands_ready),
        .entries(entry_bus.source)
    );

    rs_control i_rs_control (
        .clk(clk),
        .reset(reset),
        .dispatch_valid(dispatch_valid),
        .operands_ready(operands_ready),
        .alloc_onehot(alloc_onehot),
        .grant_onehot(grant_onehot),
        .full(full)
    );

    rs_issue_register i_rs_issue_register (
        .clk(clk),
        .reset(reset),
        .grant_onehot(grant_onehot),
        .entries(entry_bus.sink),
        .issue_valid(issue_valid),
        .issue_pc(issue_pc),
        .issue_rd(issue_rd),
        .issue_aluop(issue_aluop),
        .issue_operand1(issue_operand1),
        .issue_operand2(issue_operand2)
    );

endmodule

//--- bench/tb_div_reservation_station.sv
module tb_div_reservation_station import rs_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [pc_width-1:0] pc;
        logic [tag_width-1:0] rd;
        logic [aluop_width-1:0] aluop;
        logic [data_width-1:0] op1;
        logic [data_width-1:0] op2;
    } issue_t;

    logic clk;
    logic reset;
    logic dispatch_valid;
    logic [pc_width-1:0] dispatch_pc;
    logic [tag_width-1:0] dispatch_rd;
    logic [aluop_width-1:0] dispatch_aluop;
    logic [tag_width-1:0] dispatch_tag1;
    logic [tag_width-1:0] dispatch_tag2;
    logic [data_width-1:0] dispatch_data1;
    logic [data_width-1:0] dispatch_data2;
    logic dispatch_ready1;
    logic dispatch_ready2;
    logic alu_valid;
    logic [tag_width-1:0] alu_tag;
    logic [data_width-1:0] alu_data;
    logic mul_valid;
    logic [tag_width-1:0] mul_tag;
    logic [data_width-1:0] mul_data;
    logic div_valid;
    logic [tag_width-1:0] div_tag;
    logic [data_width-1:0] div_data;
    logic mem_read;
    logic [tag_width-1:0] mem_tag;
    logic [data_width-1:0] mem_data;
    logic full;
    logic issue_valid;
    logic [pc_width-1:0] issue_pc;
    logic [tag_width-1:0] issue_rd;
    logic [aluop_width-1:0] issue_aluop;
    logic [data_width-1:0] issue_operand1;
    logic [data_width-1:0] issue_operand2;

    // reference model, one record per slot
    logic [rs_entries-1:0] m_busy;
    issue_t m_entry [rs_entries];
    logic [tag_width-1:0] m_tag1 [rs_entries];
    logic [tag_width-1:0] m_tag2 [rs_entries];
    logic m_rdy1 [rs_entries];
    logic m_rdy2 [rs_entries];
    issue_t expect_q [$];

    string test_name = "startup";
    int errors = 0;
    int errors_at_start = 0;
    int tests_run = 0;
    int tests_failed = 0;

    div_reservation_station i_div_reservation_station (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic bus_hit(input logic [tag_width-1:0] tag,
                                     output logic [data_width-1:0] data);
        data = '0;
        if (alu_valid && alu_tag == tag) begin
            data = alu_data;
            return 1'b1;
        end
        if (mul_valid && mul_tag == tag) begin
            data = mul_data;
            return 1'b1;
        end
        if (div_valid && div_tag == tag) begin
            data = div_data;
            return 1'b1;
        end
        if (mem_read && mem_tag == tag) begin
            data = mem_data;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic model_step();
        logic [rs_entries-1:0] busy_before;
        logic granted;
        logic placed;
        logic [data_width-1:0] d;
        busy_before = m_busy;
        granted = 1'b0;
        placed = !dispatch_valid;
        for (int i = 0; i < rs_entries; i++) begin
            if (!granted && busy_before[i] && m_rdy1[i] && m_rdy2[i]) begin
                granted = 1'b1; // lowest ready slot only
                expect_q.push_back(m_entry[i]);
                m_busy[i] = 1'b0;
            end else if (busy_before[i]) begin
                if (!m_rdy1[i] && bus_hit(m_tag1[i], d)) begin
                    m_rdy1[i] = 1'b1;
                    m_entry[i].op1 = d;
                end
                if (!m_rdy2[i] && bus_hit(m_tag2[i], d)) begin
                    m_rdy2[i] = 1'b1;
                    m_entry[i].op2 = d;
                end
            end
            if (!placed && !busy_before[i]) begin
                placed = 1'b1;
                m_busy[i] = 1'b1;
                m_entry[i] = '{dispatch_pc, dispatch_rd, dispatch_aluop,
                               dispatch_data1, dispatch_data2};
                m_tag1[i] = dispatch_tag1;
                m_tag2[i] = dispatch_tag2;
                m_rdy1[i] = dispatch_ready1;
                m_rdy2[i] = dispatch_ready2;
                if (!dispatch_ready1 && bus_hit(dispatch_tag1, d)) begin
                    m_rdy1[i] = 1'b1;
                    m_entry[i].op1 = d;
                end
                if (!dispatch_ready2 && bus_hit(dispatch_tag2, d)) begin
                    m_rdy2[i] = 1'b1;
                    m_entry[i].op2 = d;
                end
            end
        end
    endtask

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            m_busy = '0;
            expect_q.delete();
        end else begin
            model_step();
        end
    end

    task automatic compare_field(input string field, input logic [data_width-1:0] expected,
                                 input logic [data_width-1:0] actual);
        assert (expected == actual) else begin
            $display("FAIL %s %s expected %h actual %h", test_name, field, expected, actual);
            errors++;
        end
    endtask

    task automatic expect_bit(input string what, input logic expected, input logic actual);
        assert (expected === actual) else begin
            $display("FAIL %s %s expected %b actual %b", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_outputs();
        issue_t exp;
        expect_bit("full", &m_busy, full);
        if (issue_valid) begin
            assert (expect_q.size() > 0) else begin
                $display("%s: an issue came out while no entry was ready", test_name);
                errors++;
            end
            if (expect_q.size() > 0) begin
                exp = expect_q.pop_front();
                compare_field("pc", exp.pc, issue_pc);
                compare_field("rd", data_width'(exp.rd), data_width'(issue_rd));
                compare_field("aluop", data_width'(exp.aluop), data_width'(issue_aluop));
                compare_field("operand1", exp.op1, issue_operand1);
                compare_field("operand2", exp.op2, issue_operand2);
            end
        end else begin
            assert (expect_q.size() == 0) else begin
                $display("%s: an expected issue did not come out", test_name);
                errors++;
                expect_q.delete();
            end
        end
    endtask

    // outputs only move on the rising edge
    always @(negedge clk) begin
        if (!reset) begin
            check_outputs();
        end
    end

    task automatic clear_inputs();
        dispatch_valid = 1'b0;
        dispatch_pc = '0;
        dispatch_rd = '0;
        dispatch_aluop = '0;
        dispatch_tag1 = '0;
        dispatch_tag2 = '0;
        dispatch_data1 = '0;
        dispatch_data2 = '0;
        dispatch_ready1 = 1'b0;
        dispatch_ready2 = 1'b0;
        {alu_valid, mul_valid, div_valid, mem_read} = '0;
        {alu_tag, mul_tag, div_tag, mem_tag} = '0;
        {alu_data, mul_data, div_data, mem_data} = '0;
    endtask

    task automatic set_bus(input int src, input logic [tag_width-1:0] tag,
                           input logic [data_width-1:0] data);
        case (src)
            src_alu: {alu_valid, alu_tag, alu_data} = {1'b1, tag, data};
            src_mul: {mul_valid, mul_tag, mul_data} = {1'b1, tag, data};
            src_div: {div_valid, div_tag, div_data} = {1'b1, tag, data};
            default: {mem_read, mem_tag, mem_data} = {1'b1, tag, data};
        endcase
    endtask

    task automatic send_dispatch(input logic [tag_width-1:0] tag1, input logic ready1,
                                 input logic [tag_width-1:0] tag2, input logic ready2);
        @(negedge clk);
        clear_inputs();
        dispatch_valid = 1'b1;
        dispatch_pc = $urandom;
        dispatch_rd = tag_width'($urandom);
        dispatch_aluop = aluop_width'($urandom);
        dispatch_tag1 = tag1;
        dispatch_tag2 = tag2;
        dispatch_data1 = $urandom;
        dispatch_data2 = $urandom;
        dispatch_ready1 = ready1;
        dispatch_ready2 = ready2;
    endtask

    task automatic broadcast(input int src, input logic [tag_width-1:0] tag);
        @(negedge clk);
        clear_inputs();
        set_bus(src, tag, $urandom);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            clear_inputs();
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            clear_inputs();
            cycles++;
        end while ((m_busy != '0 || issue_valid) && cycles < 200);
        if (m_busy != '0 || issue_valid) begin
            $display("%s: timed out waiting for the station to drain", test_name);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        @(posedge clk); // let the last check settle
        tests_run++;
        if (errors == errors_at_start) begin
            $display("%s: ok", test_name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    initial begin
        void'($urandom(18363));
        clear_inputs();
        reset = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        start_test("reset");
        idle(1);
        expect_bit("issue_valid", 1'b0, issue_valid);
        expect_bit("full", 1'b0, full);
        idle(8);
        end_test();

        start_test("ready dispatch");
        send_dispatch(8'h01, 1'b1, 8'h02, 1'b1);
        idle(1);
        expect_bit("issue_valid one cycle after", 1'b0, issue_valid);
        idle(1);
        expect_bit("issue_valid two cycles after", 1'b1, issue_valid);
        idle(1);
        expect_bit("issue_valid pulse end", 1'b0, issue_valid);
        wait_drain();
        end_test();

        start_test("dispatch forwarding");
        send_dispatch(8'h11, 1'b0, 8'h12, 1'b0);
        set_bus(src_alu, 8'h11, $urandom);
        set_bus(src_mem, 8'h12, $urandom);
        for (int s = 0; s < num_sources; s++) begin
            send_dispatch(8'h14, 1'b0, 8'h00, 1'b1);
            for (int b = s; b < num_sources; b++) begin
                set_bus(b, 8'h14, $urandom); // all of them match, s wins
            end
        end
        wait_drain();
        send_dispatch(8'h15, 1'b0, 8'h00, 1'b1);
        alu_tag = 8'h15; // valid stays low
        alu_data = $urandom;
        idle(5);
        broadcast(src_mem, 8'h15);
        wait_drain();
        end_test();

        start_test("later wakeup");
        send_dispatch(8'h21, 1'b0, 8'h22, 1'b0);
        idle(6);
        broadcast(src_alu, 8'h21);
        idle(4);
        broadcast(src_div, 8'h22);
        idle(1);
        expect_bit("issue_valid one cycle after wakeup", 1'b0, issue_valid);
        idle(1);
        expect_bit("issue_valid two cycles after wakeup", 1'b1, issue_valid);
        wait_drain();
        end_test();

        start_test("issue order");
        for (int i = 0; i < 4; i++) begin
            send_dispatch(8'h00, 1'b1, 8'h33, 1'b0);
        end
        idle(3);
        broadcast(src_div, 8'h33); // four entries ready at once
        wait_drain();
        for (int i = 0; i < 3; i++) begin
            send_dispatch(8'h00, 1'b1, 8'h00, 1'b1);
        end
        wait_drain();
        end_test();

        start_test("full station");
        for (int i = 0; i < rs_entries; i++) begin
            send_dispatch(tag_width'(8'h40 + i), 1'b0, 8'h00, 1'b1);
        end
        idle(1);
        expect_bit("full after sixteen", 1'b1, full);
        send_dispatch(8'h7f, 1'b0, 8'h00, 1'b1); // dropped
        idle(1);
        broadcast(src_mul, 8'h45);
        idle(2);
        expect_bit("full after wakeup", 1'b0, full);
        send_dispatch(8'h00, 1'b1, 8'h00, 1'b1);
        idle(3);
        broadcast(src_alu, 8'h7f);
        for (int i = 0; i < rs_entries; i++) begin
            broadcast(src_mem, tag_width'(8'h40 + i));
        end
        wait_drain();
        end_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
source/rs_pkg.sv
source/rs_interfaces.sv
source/rs_operand_forward.sv
source/rs_entry_array.sv
source/rs_control.sv
source/rs_issue_register.sv
source/div_reservation_station.sv
bench/tb_div_reservation_station.sv

//--- run_verilator.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_div_reservation_station \
    -f verilog.f \
    -o sim_div_reservation_station

./obj_dir/sim_div_reservation_station | tee sim.log

if grep -qx "Regression passed" sim.log; then
    echo "simulation ok"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
